// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert -f build.f --top-module decodeTb
	obj_dir/VdecodeTb

clean:
	rm -rf obj_dir

// File: build.f
+incdir+tb
design/isaPkg.sv
design/ctrlPkg.sv
design/specialDecoder.sv
design/extOpDecoder.sv
design/immMemDecoder.sv
design/branchJumpDecoder.sv
design/idExStage.sv
design/decodeTop.sv
tb/decodeTb.sv

// File: design/branchJumpDecoder.sv
module branchJumpDecoder (
    input  isaPkg::instrT     instr,
    output logic              hit,
    output ctrlPkg::ctrlWordT word
);

    always_comb begin
        hit  = 1'b1;
        word = ctrlPkg::ctrlIdle;

        case (instr.opcode)
            isaPkg::opRegimm: begin
                word.branch = 1'b1;
                case (instr.rt)
                    isaPkg::rtBgez: word.aluOp = ctrlPkg::aluBgez;
                    isaPkg::rtBltz: word.aluOp = ctrlPkg::aluBltz;
                    default:        word = ctrlPkg::ctrlIdle;
                endcase
            end
            isaPkg::opBeq: begin
                word.branch = 1'b1;
                word.aluOp  = ctrlPkg::aluBeq;
            end
            isaPkg::opBne: begin
                word.branch = 1'b1;
                word.aluOp  = ctrlPkg::aluBne;
            end
            isaPkg::opBgtz: begin
                word.branch = 1'b1;
                word.aluOp  = ctrlPkg::aluBgtz;
            end
            isaPkg::opBlez: begin
                word.branch = 1'b1;
                word.aluOp  = ctrlPkg::aluBlez;
            end
            isaPkg::opJ: begin
                word.jump    = 1'b1;
                word.aluSrc2 = 1'b1;      // Target from the index field
            end
            isaPkg::opJal: begin
                word.jump     = 1'b1;
                word.aluSrc2  = 1'b1;
                word.regDst   = ctrlPkg::dstRa;   // Link address to r31
                word.regWrite = 1'b1;
            end
            default: hit = 1'b0;
        endcase
    end

endmodule

// File: design/ctrlPkg.sv
package ctrlPkg;

    localparam int aluOpW = 5;

    // Codes 0 to 25 follow the ALU, 26 and up were free
    typedef enum logic [aluOpW-1:0] {
        aluAdd  = 5'd0,  aluSub  = 5'd1,  aluMult = 5'd2,  aluAnd  = 5'd3,
        aluOr   = 5'd4,  aluNor  = 5'd5,  aluXor  = 5'd6,  aluSll  = 5'd7,
        aluSrl  = 5'd8,  aluRotr = 5'd9,  aluSlt  = 5'd10, aluMovn = 5'd11,
        aluMovz = 5'd12, aluSra  = 5'd13, aluSltu = 5'd14, aluMthi = 5'd15,
        aluMtlo = 5'd16, aluMfhi = 5'd17, aluMflo = 5'd18, aluMul  = 5'd19,
        aluMadd = 5'd20, aluMsub = 5'd21, aluSeh  = 5'd22, aluSeb  = 5'd23,
        aluBgez = 5'd24, aluBltz = 5'd25, aluBeq  = 5'd26, aluBne  = 5'd27,
        aluBgtz = 5'd28, aluBlez = 5'd29, aluLui  = 5'd30, aluNone = 5'd31
    } aluOpT;

    // Write-back register select
    typedef enum logic [1:0] {
        dstRt = 2'd0,
        dstRd = 2'd1,
        dstRa = 2'd2     // r31 for jal
    } regDstT;

    typedef enum logic [1:0] {
        dtWord = 2'd0,
        dtHalf = 2'd1,
        dtByte = 2'd2
    } dataTypeT;

    typedef enum logic [1:0] {
        hlNone = 2'd0,
        hlHi   = 2'd1,
        hlLo   = 2'd2,
        hlBoth = 2'd3
    } hiLoWriteT;

    // Decode-to-execute control word, 20 bits
    typedef struct packed {
        regDstT    regDst;
        logic      aluSrc;      // Immediate as second operand
        logic      aluSrc2;     // Shift amount or jump target field
        logic      memToReg;
        logic      regWrite;
        logic      memRead;
        logic      memWrite;
        logic      branch;
        logic      jump;
        dataTypeT  dataType;
        hiLoWriteT hiLoWrite;
        aluOpT     aluOp;
        logic      zeroExtImm;
    } ctrlWordT;

    localparam ctrlWordT ctrlIdle = '{
        regDst:     dstRt,
        aluSrc:     1'b0,
        aluSrc2:    1'b0,
        memToReg:   1'b0,
        regWrite:   1'b0,
        memRead:    1'b0,
        memWrite:   1'b0,
        branch:     1'b0,
        jump:       1'b0,
        dataType:   dtWord,
        hiLoWrite:  hlNone,
        aluOp:      aluNone,
        zeroExtImm: 1'b0
    };

endpackage

// File: design/decodeTop.sv
module decodeTop (
    input  logic              Clk,
    input  logic              rstN,
    input  logic              instrValid,
    input  isaPkg::instrT     instr,
    output logic              ctrlValid,
    output ctrlPkg::ctrlWordT ctrl
);

    logic              specialHit;
    logic              extHit;
    logic              immMemHit;
    logic              branchJumpHit;
    ctrlPkg::ctrlWordT specialWord;
    ctrlPkg::ctrlWordT extWord;
    ctrlPkg::ctrlWordT immMemWord;
    ctrlPkg::ctrlWordT branchJumpWord;

    specialDecoder uSpecial (.instr(instr), .hit(specialHit), .word(specialWord));

    extOpDecoder uExtOp (.instr(instr), .hit(extHit), .word(extWord));

    immMemDecoder uImmMem (.instr(instr), .hit(immMemHit), .word(immMemWord));

    branchJumpDecoder uBranchJump (.instr(instr), .hit(branchJumpHit), .word(branchJumpWord));

    idExStage uStage (
        .Clk            (Clk),
        .rstN           (rstN),
        .instrValid     (instrValid),
        .specialHit     (specialHit),
        .specialWord    (specialWord),
        .extHit         (extHit),
        .extWord        (extWord),
        .immMemHit      (immMemHit),
        .immMemWord     (immMemWord),
        .branchJumpHit  (branchJumpHit),
        .branchJumpWord (branchJumpWord),
        .ctrlValid      (ctrlValid),
        .ctrl           (ctrl)
    );

endmodule

// File: design/extOpDecoder.sv
module extOpDecoder (
    input  isaPkg::instrT     instr,
    output logic              hit,
    output ctrlPkg::ctrlWordT word
);

    assign hit = (instr.opcode == isaPkg::opSpecial2) ||
                 (instr.opcode == isaPkg::opSpecial3);

    always_comb begin
        word          = ctrlPkg::ctrlIdle;
        word.regDst   = ctrlPkg::dstRd;
        word.regWrite = 1'b1;

        if (instr.opcode == isaPkg::opSpecial2) begin
            // Multiply group
            case (instr.funct)
                isaPkg::fnMul:  word.aluOp = ctrlPkg::aluMul;   // Result to rd only
                isaPkg::fnMadd: begin
                    word.aluOp     = ctrlPkg::aluMadd;
                    word.hiLoWrite = ctrlPkg::hlBoth;
                end
                isaPkg::fnMsub: begin
                    word.aluOp     = ctrlPkg::aluMsub;
                    word.hiLoWrite = ctrlPkg::hlBoth;
                end
                default:        word = ctrlPkg::ctrlIdle;
            endcase
        end else begin
            // Sign extend, picked by shamt
            case (instr.shamt)
                isaPkg::saSeb: word.aluOp = ctrlPkg::aluSeb;
                isaPkg::saSeh: word.aluOp = ctrlPkg::aluSeh;
                default:       word = ctrlPkg::ctrlIdle;
            endcase
        end
    end

endmodule

// File: design/idExStage.sv
module idExStage (
    input  logic              Clk,
    input  logic              rstN,
    input  logic              instrValid,
    input  logic              specialHit,
    input  ctrlPkg::ctrlWordT specialWord,
    input  logic              extHit,
    input  ctrlPkg::ctrlWordT extWord,
    input  logic              immMemHit,
    input  ctrlPkg::ctrlWordT immMemWord,
    input  logic              branchJumpHit,
    input  ctrlPkg::ctrlWordT branchJumpWord,
    output logic              ctrlValid,
    output ctrlPkg::ctrlWordT ctrl
);

    ctrlPkg::ctrlWordT nextCtrl;

    // Decoders claim disjoint opcodes, so order here is arbitrary
    always_comb begin
        nextCtrl = ctrlPkg::ctrlIdle;      // Unknown opcode
        if (specialHit)         nextCtrl = specialWord;
        else if (extHit)        nextCtrl = extWord;
        else if (immMemHit)     nextCtrl = immMemWord;
        else if (branchJumpHit) nextCtrl = branchJumpWord;
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            ctrlValid <= 1'b0;
            ctrl      <= ctrlPkg::ctrlIdle;
        end else begin
            ctrlValid <= instrValid;
            if (instrValid) begin
                ctrl <= nextCtrl;           // Holds while idle
            end
        end
    end

    // No two decoders may claim the same instruction
    aOneHit: assert property (@(posedge Clk) disable iff (!rstN)
        instrValid |-> $onehot0({specialHit, extHit, immMemHit, branchJumpHit}));

    aNoReadWrite: assert property (@(posedge Clk) disable iff (!rstN)
        ctrlValid |-> !(ctrl.memRead && ctrl.memWrite));

    // A store never writes the register file
    aStoreNoWb: assert property (@(posedge Clk) disable iff (!rstN)
        ctrlValid |-> !(ctrl.memWrite && ctrl.regWrite));

endmodule

// File: design/immMemDecoder.sv
module immMemDecoder (
    input  isaPkg::instrT     instr,
    output logic              hit,
    output ctrlPkg::ctrlWordT word
);

    logic isImm;
    logic isLoad;
    logic isStore;

    always_comb begin
        isImm   = 1'b0;
        isLoad  = 1'b0;
        isStore = 1'b0;
        word    = ctrlPkg::ctrlIdle;

        case (instr.opcode)
            isaPkg::opAddi,
            isaPkg::opAddiu: begin
                isImm      = 1'b1;
                word.aluOp = ctrlPkg::aluAdd;
            end
            isaPkg::opAndi: begin
                isImm           = 1'b1;
                word.aluOp      = ctrlPkg::aluAnd;
                word.zeroExtImm = 1'b1;
            end
            isaPkg::opOri: begin
                isImm           = 1'b1;
                word.aluOp      = ctrlPkg::aluOr;
                word.zeroExtImm = 1'b1;
            end
            isaPkg::opXori: begin
                isImm           = 1'b1;
                word.aluOp      = ctrlPkg::aluXor;
                word.zeroExtImm = 1'b1;
            end
            isaPkg::opSlti:  begin isImm = 1'b1; word.aluOp = ctrlPkg::aluSlt;  end
            isaPkg::opSltiu: begin isImm = 1'b1; word.aluOp = ctrlPkg::aluSltu; end
            isaPkg::opLui:   begin isImm = 1'b1; word.aluOp = ctrlPkg::aluLui;  end
            isaPkg::opLw:    begin isLoad = 1'b1;  word.dataType = ctrlPkg::dtWord; end
            isaPkg::opLh:    begin isLoad = 1'b1;  word.dataType = ctrlPkg::dtHalf; end
            isaPkg::opLb:    begin isLoad = 1'b1;  word.dataType = ctrlPkg::dtByte; end
            isaPkg::opSw:    begin isStore = 1'b1; word.dataType = ctrlPkg::dtWord; end
            isaPkg::opSh:    begin isStore = 1'b1; word.dataType = ctrlPkg::dtHalf; end
            isaPkg::opSb:    begin isStore = 1'b1; word.dataType = ctrlPkg::dtByte; end
            default: ;
        endcase

        if (isLoad || isStore) begin
            word.aluOp = ctrlPkg::aluAdd;       // Base plus offset
        end
        word.aluSrc   = isImm || isLoad || isStore;
        word.regWrite = isImm || isLoad;        // regDst stays rt
        word.memToReg = isLoad;
        word.memRead  = isLoad;
        word.memWrite = isStore;
    end

    assign hit = isImm || isLoad || isStore;

endmodule

// File: design/isaPkg.sv
package isaPkg;

    // 32-bit instruction word, opcode in the top bits
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instrT;

    // Primary opcodes
    localparam logic [5:0] opSpecial  = 6'b000000;
    localparam logic [5:0] opRegimm   = 6'b000001;
    localparam logic [5:0] opJ        = 6'b000010;
    localparam logic [5:0] opJal      = 6'b000011;
    localparam logic [5:0] opBeq      = 6'b000100;
    localparam logic [5:0] opBne      = 6'b000101;
    localparam logic [5:0] opBlez     = 6'b000110;
    localparam logic [5:0] opBgtz     = 6'b000111;
    localparam logic [5:0] opAddi     = 6'b001000;
    localparam logic [5:0] opAddiu    = 6'b001001;
    localparam logic [5:0] opSlti     = 6'b001010;
    localparam logic [5:0] opSltiu    = 6'b001011;
    localparam logic [5:0] opAndi     = 6'b001100;
    localparam logic [5:0] opOri      = 6'b001101;
    localparam logic [5:0] opXori     = 6'b001110;
    localparam logic [5:0] opLui      = 6'b001111;
    localparam logic [5:0] opSpecial2 = 6'b011100;
    localparam logic [5:0] opSpecial3 = 6'b011111;
    localparam logic [5:0] opLb       = 6'b100000;
    localparam logic [5:0] opLh       = 6'b100001;
    localparam logic [5:0] opLw       = 6'b100011;
    localparam logic [5:0] opSb       = 6'b101000;
    localparam logic [5:0] opSh       = 6'b101001;
    localparam logic [5:0] opSw       = 6'b101011;

    // SPECIAL function codes
    localparam logic [5:0] fnSll   = 6'b000000;
    localparam logic [5:0] fnSrl   = 6'b000010;   // Also rotr
    localparam logic [5:0] fnSra   = 6'b000011;
    localparam logic [5:0] fnSllv  = 6'b000100;
    localparam logic [5:0] fnSrlv  = 6'b000110;   // Also rotrv
    localparam logic [5:0] fnSrav  = 6'b000111;
    localparam logic [5:0] fnJr    = 6'b001000;
    localparam logic [5:0] fnMovz  = 6'b001010;
    localparam logic [5:0] fnMovn  = 6'b001011;
    localparam logic [5:0] fnMfhi  = 6'b010000;
    localparam logic [5:0] fnMthi  = 6'b010001;
    localparam logic [5:0] fnMflo  = 6'b010010;
    localparam logic [5:0] fnMtlo  = 6'b010011;
    localparam logic [5:0] fnMult  = 6'b011000;
    localparam logic [5:0] fnMultu = 6'b011001;
    localparam logic [5:0] fnAdd   = 6'b100000;
    localparam logic [5:0] fnAddu  = 6'b100001;
    localparam logic [5:0] fnSub   = 6'b100010;
    localparam logic [5:0] fnAnd   = 6'b100100;
    localparam logic [5:0] fnOr    = 6'b100101;
    localparam logic [5:0] fnXor   = 6'b100110;
    localparam logic [5:0] fnNor   = 6'b100111;
    localparam logic [5:0] fnSlt   = 6'b101010;
    localparam logic [5:0] fnSltu  = 6'b101011;

    // SPECIAL2 function codes
    localparam logic [5:0] fnMadd = 6'b000000;
    localparam logic [5:0] fnMul  = 6'b000010;
    localparam logic [5:0] fnMsub = 6'b000100;

    // Sub-codes in rt, rs and shamt
    localparam logic [4:0] rtBltz  = 5'b00000;
    localparam logic [4:0] rtBgez  = 5'b00001;
    localparam logic [4:0] saSeb   = 5'b10000;
    localparam logic [4:0] saSeh   = 5'b11000;
    localparam logic [4:0] saSrlv  = 5'b00000;
    localparam logic [4:0] saRotrv = 5'b00001;
    localparam int         rotrRsBit = 0;      // rs bit that turns srl into rotr

endpackage

// File: design/specialDecoder.sv
module specialDecoder (
    input  isaPkg::instrT     instr,
    output logic              hit,
    output ctrlPkg::ctrlWordT word
);

    assign hit = (instr.opcode == isaPkg::opSpecial);

    always_comb begin
        word          = ctrlPkg::ctrlIdle;
        word.regDst   = ctrlPkg::dstRd;
        word.regWrite = 1'b1;

        case (instr.funct)
            isaPkg::fnAdd,
            isaPkg::fnAddu:  word.aluOp = ctrlPkg::aluAdd;
            isaPkg::fnSub:   word.aluOp = ctrlPkg::aluSub;
            isaPkg::fnMult,
            isaPkg::fnMultu: begin
                word.aluOp     = ctrlPkg::aluMult;
                word.hiLoWrite = ctrlPkg::hlBoth;
            end
            isaPkg::fnAnd:   word.aluOp = ctrlPkg::aluAnd;
            isaPkg::fnOr:    word.aluOp = ctrlPkg::aluOr;
            isaPkg::fnNor:   word.aluOp = ctrlPkg::aluNor;
            isaPkg::fnXor:   word.aluOp = ctrlPkg::aluXor;
            isaPkg::fnSll: begin
                word.aluOp   = ctrlPkg::aluSll;
                word.aluSrc2 = 1'b1;              // Shift by shamt
            end
            isaPkg::fnSllv:  word.aluOp = ctrlPkg::aluSll;
            isaPkg::fnSrl: begin
                word.aluSrc2 = 1'b1;
                word.aluOp   = instr.rs[isaPkg::rotrRsBit] ? ctrlPkg::aluRotr
                                                           : ctrlPkg::aluSrl;
            end
            isaPkg::fnSrlv: begin
                case (instr.shamt)
                    isaPkg::saSrlv:  word.aluOp = ctrlPkg::aluSrl;
                    isaPkg::saRotrv: word.aluOp = ctrlPkg::aluRotr;
                    default:         word = ctrlPkg::ctrlIdle;
                endcase
            end
            isaPkg::fnSra: begin
                word.aluOp   = ctrlPkg::aluSra;
                word.aluSrc2 = 1'b1;
            end
            isaPkg::fnSrav:  word.aluOp = ctrlPkg::aluSra;
            isaPkg::fnSlt:   word.aluOp = ctrlPkg::aluSlt;
            isaPkg::fnSltu:  word.aluOp = ctrlPkg::aluSltu;
            isaPkg::fnMovn:  word.aluOp = ctrlPkg::aluMovn;
            isaPkg::fnMovz:  word.aluOp = ctrlPkg::aluMovz;
            isaPkg::fnMthi: begin
                word.aluOp     = ctrlPkg::aluMthi;
                word.hiLoWrite = ctrlPkg::hlHi;
            end
            isaPkg::fnMtlo: begin
                word.aluOp     = ctrlPkg::aluMtlo;
                word.hiLoWrite = ctrlPkg::hlLo;
            end
            isaPkg::fnMfhi:  word.aluOp = ctrlPkg::aluMfhi;
            isaPkg::fnMflo:  word.aluOp = ctrlPkg::aluMflo;
            isaPkg::fnJr:    word.jump  = 1'b1;   // ALU stays idle
            default:         word = ctrlPkg::ctrlIdle;
        endcase

        // sll r0,r0,0 is the canonical nop
        if (instr == '0) begin
            word = ctrlPkg::ctrlIdle;
        end
    end

endmodule

// File: tb/decodeRef.svh
`ifndef decodeRefSvh
`define decodeRefSvh

// Pack the six fields into an instruction word
function automatic isaPkg::instrT encodeInstr(
    logic [5:0] op,
    logic [4:0] rs,
    logic [4:0] rt,
    logic [4:0] rd,
    logic [4:0] sa,
    logic [5:0] fn
);
    isaPkg::instrT w;
    w = '{opcode: op, rs: rs, rt: rt, rd: rd, shamt: sa, funct: fn};
    return w;
endfunction

// Opcodes of the kept groups for random draws
function automatic logic [5:0] keptOpcode(logic [4:0] sel);
    logic [5:0] op;
    if (!sel[4]) begin
        op = {2'b00, sel[3:0]};   // 0 to 15 all decode
    end else begin
        case (sel[2:0])
            3'd0:    op = isaPkg::opSpecial2;
            3'd1:    op = isaPkg::opSpecial3;
            3'd2:    op = isaPkg::opLb;
            3'd3:    op = isaPkg::opLh;
            3'd4:    op = isaPkg::opLw;
            3'd5:    op = isaPkg::opSb;
            3'd6:    op = isaPkg::opSh;
            default: op = isaPkg::opSw;
        endcase
    end
    return op;
endfunction

// Expected control word for one instruction
function automatic ctrlPkg::ctrlWordT refDecode(isaPkg::instrT i);
    ctrlPkg::ctrlWordT w;
    logic              known;
    w     = ctrlPkg::ctrlIdle;
    known = 1'b1;
    case (i.opcode)
        isaPkg::opSpecial: begin
            w.regDst   = ctrlPkg::dstRd;
            w.regWrite = 1'b1;
            case (i.funct)
                isaPkg::fnAdd, isaPkg::fnAddu: w.aluOp = ctrlPkg::aluAdd;
                isaPkg::fnSub:  w.aluOp = ctrlPkg::aluSub;
                isaPkg::fnAnd:  w.aluOp = ctrlPkg::aluAnd;
                isaPkg::fnOr:   w.aluOp = ctrlPkg::aluOr;
                isaPkg::fnNor:  w.aluOp = ctrlPkg::aluNor;
                isaPkg::fnXor:  w.aluOp = ctrlPkg::aluXor;
                isaPkg::fnSlt:  w.aluOp = ctrlPkg::aluSlt;
                isaPkg::fnSltu: w.aluOp = ctrlPkg::aluSltu;
                isaPkg::fnMovn: w.aluOp = ctrlPkg::aluMovn;
                isaPkg::fnMovz: w.aluOp = ctrlPkg::aluMovz;
                isaPkg::fnMfhi: w.aluOp = ctrlPkg::aluMfhi;
                isaPkg::fnMflo: w.aluOp = ctrlPkg::aluMflo;
                isaPkg::fnSllv: w.aluOp = ctrlPkg::aluSll;
                isaPkg::fnSrav: w.aluOp = ctrlPkg::aluSra;
                isaPkg::fnSll:  begin w.aluOp = ctrlPkg::aluSll; w.aluSrc2 = 1'b1; end
                isaPkg::fnSra:  begin w.aluOp = ctrlPkg::aluSra; w.aluSrc2 = 1'b1; end
                isaPkg::fnSrl: begin
                    w.aluSrc2 = 1'b1;
                    w.aluOp   = i.rs[0] ? ctrlPkg::aluRotr : ctrlPkg::aluSrl;
                end
                isaPkg::fnSrlv: begin
                    if (i.shamt == 5'd0)      w.aluOp = ctrlPkg::aluSrl;
                    else if (i.shamt == 5'd1) w.aluOp = ctrlPkg::aluRotr;
                    else                      known = 1'b0;
                end
                isaPkg::fnMult, isaPkg::fnMultu: begin
                    w.aluOp     = ctrlPkg::aluMult;
                    w.hiLoWrite = ctrlPkg::hlBoth;
                end
                isaPkg::fnMthi: begin w.aluOp = ctrlPkg::aluMthi; w.hiLoWrite = ctrlPkg::hlHi; end
                isaPkg::fnMtlo: begin w.aluOp = ctrlPkg::aluMtlo; w.hiLoWrite = ctrlPkg::hlLo; end
                isaPkg::fnJr:   w.jump = 1'b1;
                default:        known = 1'b0;
            endcase
        end
        isaPkg::opSpecial2: begin
            w.regDst   = ctrlPkg::dstRd;
            w.regWrite = 1'b1;
            case (i.funct)
                isaPkg::fnMul:  w.aluOp = ctrlPkg::aluMul;
                isaPkg::fnMadd: begin w.aluOp = ctrlPkg::aluMadd; w.hiLoWrite = ctrlPkg::hlBoth; end
                isaPkg::fnMsub: begin w.aluOp = ctrlPkg::aluMsub; w.hiLoWrite = ctrlPkg::hlBoth; end
                default:        known = 1'b0;
            endcase
        end
        isaPkg::opSpecial3: begin
            w.regDst   = ctrlPkg::dstRd;
            w.regWrite = 1'b1;
            if (i.shamt == isaPkg::saSeb)      w.aluOp = ctrlPkg::aluSeb;
            else if (i.shamt == isaPkg::saSeh) w.aluOp = ctrlPkg::aluSeh;
            else                               known = 1'b0;
        end
        isaPkg::opAddi, isaPkg::opAddiu, isaPkg::opSlti, isaPkg::opSltiu,
        isaPkg::opAndi, isaPkg::opOri, isaPkg::opXori, isaPkg::opLui: begin
            w.aluSrc   = 1'b1;
            w.regWrite = 1'b1;
            case (i.opcode)
                isaPkg::opSlti:  w.aluOp = ctrlPkg::aluSlt;
                isaPkg::opSltiu: w.aluOp = ctrlPkg::aluSltu;
                isaPkg::opAndi:  begin w.aluOp = ctrlPkg::aluAnd; w.zeroExtImm = 1'b1; end
                isaPkg::opOri:   begin w.aluOp = ctrlPkg::aluOr;  w.zeroExtImm = 1'b1; end
                isaPkg::opXori:  begin w.aluOp = ctrlPkg::aluXor; w.zeroExtImm = 1'b1; end
                isaPkg::opLui:   w.aluOp = ctrlPkg::aluLui;
                default:         w.aluOp = ctrlPkg::aluAdd;   // addi, addiu
            endcase
        end
        isaPkg::opLb, isaPkg::opLh, isaPkg::opLw,
        isaPkg::opSb, isaPkg::opSh, isaPkg::opSw: begin
            w.aluSrc = 1'b1;
            w.aluOp  = ctrlPkg::aluAdd;
            // Width from the two low opcode bits
            w.dataType = (i.opcode[1:0] == 2'b11) ? ctrlPkg::dtWord
                       : (i.opcode[0] ? ctrlPkg::dtHalf : ctrlPkg::dtByte);
            if (i.opcode[3]) begin
                w.memWrite = 1'b1;
            end else begin
                w.memRead  = 1'b1;
                w.memToReg = 1'b1;
                w.regWrite = 1'b1;
            end
        end
        isaPkg::opRegimm: begin
            w.branch = 1'b1;
            if (i.rt == isaPkg::rtBgez)      w.aluOp = ctrlPkg::aluBgez;
            else if (i.rt == isaPkg::rtBltz) w.aluOp = ctrlPkg::aluBltz;
            else                             known = 1'b0;
        end
        isaPkg::opBeq:  begin w.branch = 1'b1; w.aluOp = ctrlPkg::aluBeq;  end
        isaPkg::opBne:  begin w.branch = 1'b1; w.aluOp = ctrlPkg::aluBne;  end
        isaPkg::opBgtz: begin w.branch = 1'b1; w.aluOp = ctrlPkg::aluBgtz; end
        isaPkg::opBlez: begin w.branch = 1'b1; w.aluOp = ctrlPkg::aluBlez; end
        isaPkg::opJ:    begin w.jump = 1'b1; w.aluSrc2 = 1'b1; end
        isaPkg::opJal: begin
            w.jump     = 1'b1;
            w.aluSrc2  = 1'b1;
            w.regDst   = ctrlPkg::dstRa;
            w.regWrite = 1'b1;
        end
        default: known = 1'b0;
    endcase
    // Unknown codes and nop fall back to idle
    if (!known || i == '0) begin
        w = ctrlPkg::ctrlIdle;
    end
    return w;
endfunction

`endif

// File: tb/decodeTb.sv
module decodeTb;

    `include "decodeRef.svh"

    localparam int clkPeriod      = 40;
    localparam int directedCycles = 4 * 64 + 64 + 32 + 32 + 1;
    localparam int randomCount    = 2000;
    localparam int totalCycles    = 8 + directedCycles + randomCount;
    localparam int timeLimit      = totalCycles * clkPeriod + 400;

    logic              Clk;
    logic              rstN;
    logic              instrValid;
    isaPkg::instrT     instr;
    logic              ctrlValid;
    ctrlPkg::ctrlWordT ctrl;
    string             testName;
    int                seed = 32'he4ba_03fb;

    decodeTop dut (
        .Clk        (Clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .ctrlValid  (ctrlValid),
        .ctrl       (ctrl)
    );

    initial begin
        Clk = 1'b0;
        forever #(clkPeriod / 2) Clk = ~Clk;
    end

    task automatic checkWord(string name, ctrlPkg::ctrlWordT expected,
                             ctrlPkg::ctrlWordT actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: ctrl expected %h actual %h", name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "Control word mismatch");
        end
    endtask

    task automatic checkValid(string name, bit expected, bit actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: ctrlValid expected %b actual %b", name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "Valid mismatch");
        end
    endtask

    // One instruction per falling edge
    task automatic driveInstr(string name, isaPkg::instrT value, logic valid);
        @(negedge Clk);
        testName   = name;
        instr      = value;
        instrValid = valid;
    endtask

    // Expectation lags the inputs by one edge
    initial begin : compareProc
        ctrlPkg::ctrlWordT expWord;
        bit                expValid;
        string             expName;
        expWord  = ctrlPkg::ctrlIdle;
        expValid = 1'b0;
        expName  = "reset";
        forever begin
            @(posedge Clk);
            if (rstN) begin
                checkValid(expName, expValid, ctrlValid);
                checkWord(expName, expWord, ctrl);
                expValid = instrValid;
                expName  = testName;
                if (instrValid) begin
                    expWord = refDecode(instr);   // Otherwise ctrl holds
                end
            end
        end
    end

    initial begin : stimulus
        logic [31:0]   r;
        isaPkg::instrT x;
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        testName   = "reset";
        repeat (2) @(posedge Clk);
        @(negedge Clk);
        checkValid("reset", 1'b0, ctrlValid);
        checkWord("reset", ctrlPkg::ctrlIdle, ctrl);
        rstN = 1'b1;

        // Every primary opcode with two field sets
        for (int op = 0; op < 64; op++) begin
            driveInstr($sformatf("opcode %0d set a", op), encodeInstr(6'(op), 5'd2,
                       isaPkg::rtBgez, 5'd5, isaPkg::saSeb, isaPkg::fnAdd), 1'b1);
            driveInstr($sformatf("opcode %0d set b", op), encodeInstr(6'(op), 5'd3,
                       isaPkg::rtBltz, 5'd9, isaPkg::saSeh, isaPkg::fnMul), 1'b1);
        end
        // SPECIAL functions, plain and rotate variants
        for (int fn = 0; fn < 64; fn++) begin
            driveInstr($sformatf("special fn %0d", fn), encodeInstr(isaPkg::opSpecial,
                       5'd4, 5'd2, 5'd7, 5'd0, 6'(fn)), 1'b1);
            driveInstr($sformatf("special fn %0d rot", fn), encodeInstr(isaPkg::opSpecial,
                       5'd1, 5'd2, 5'd7, 5'd1, 6'(fn)), 1'b1);
        end
        for (int fn = 0; fn < 64; fn++) begin
            driveInstr($sformatf("special2 fn %0d", fn), encodeInstr(isaPkg::opSpecial2,
                       5'd6, 5'd8, 5'd10, 5'd0, 6'(fn)), 1'b1);
        end
        for (int sa = 0; sa < 32; sa++) begin
            driveInstr($sformatf("special3 sa %0d", sa), encodeInstr(isaPkg::opSpecial3,
                       5'd0, 5'd4, 5'd11, 5'(sa), 6'h20), 1'b1);
        end
        for (int rt = 0; rt < 32; rt++) begin
            driveInstr($sformatf("regimm rt %0d", rt), encodeInstr(isaPkg::opRegimm,
                       5'd12, 5'(rt), 5'd0, 5'd0, 6'd0), 1'b1);
        end
        driveInstr("nop", '0, 1'b1);

        // Kept opcodes with random fields, mixed with raw words
        for (int n = 0; n < randomCount; n++) begin
            r = $random(seed);
            x = $random(seed);
            if (r[1:0] != 2'b00) begin
                x.opcode = keptOpcode(r[6:2]);
                if (r[7])  x.shamt = {1'b1, r[8], 3'b000};   // seb or seh
                if (r[9])  x.funct[5:3] = 3'b000;
                if (r[10]) x.rt[4:1] = 4'b0000;              // bgez or bltz
            end
            driveInstr($sformatf("random %0d", n), x, r[12:11] != 2'b00);
        end

        driveInstr("drain", '0, 1'b0);
        repeat (2) @(posedge Clk);
        @(negedge Clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

    initial begin : watchdog
        #(timeLimit);
        $display("Timed out before the last test finished");
        $display("CHECKS FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule
